/* tests/id_stage_vectors.txt */
# in: fs_valid pc inst wb_we wb_addr wb_data es_vlw es_addr es_data ms_vw ms_addr ms_data es_ready
# out: mask ready valid taken op dest_en dest v_en v1 v2 v3 target pc (all hex)
0 0 0         1 1 11      0 0 0   0 0 0   1  00 1 0 0 00 0 00 0 0 0 0 0 0
0 0 0         1 2 22      0 0 0   0 0 0   1  00 1 0 0 00 0 00 0 0 0 0 0 0
0 0 0         1 3 33      0 0 0   0 0 0   1  00 1 0 0 00 0 00 0 0 0 0 0 0
1 100 00222821 1 0 dead   0 0 0   0 0 0   1  00 1 0 0 00 0 00 0 0 0 0 0 0
1 104 00033027 1 4 33     0 0 0   0 0 0   1  5f 1 1 0 01 1 05 6 11 22 0 0 100
1 108 00023900 1 5 400020 0 0 0   0 0 0   1  5f 1 1 0 08 1 06 6 0 33 0 0 104
1 10c 000347c3 0 0 0      0 0 0   0 0 0   1  5f 1 1 0 10 1 07 6 22 4 0 0 108
1 110 3c098001 0 0 0      0 0 0   0 0 0   1  5f 1 1 0 12 1 08 6 33 1f 0 0 10c
1 114 242afffc 0 0 0      0 0 0   0 0 0   1  5f 1 1 0 0f 1 09 4 80010000 0 0 0 110
1 118 284b8000 0 0 0      0 0 0   0 0 0   1  5f 1 1 0 09 1 0a 6 11 fffffffc 0 0 114
1 11c 306c8000 0 0 0      0 0 0   0 0 0   1  5f 1 1 0 0a 1 0b 6 22 ffff8000 0 0 118
1 120 340dfff0 0 0 0      0 0 0   0 0 0   1  5f 1 1 0 0c 1 0c 6 33 8000 0 0 11c
1 124 8c2efff8 0 0 0      0 0 0   0 0 0   1  5f 1 1 0 0d 1 0d 6 0 fff0 0 0 120
1 128 ac22000c 0 0 0      0 0 0   0 0 0   1  5f 1 1 0 13 1 0e 6 11 fffffff8 0 0 124
1 12c 00222021 0 0 0      0 0 0   0 0 0   1  5f 1 1 0 14 0 00 7 11 c 22 0 128
0 0 0         1 2 b2      5 1 e1  3 1 a1  0  5f 0 1 0 01 1 04 6 e1 b2 0 0 12c
0 0 0         1 1 b1      1 1 e1  3 1 a1  0  5f 0 1 0 01 1 04 6 a1 b2 0 0 12c
1 130 00037825 0 0 0      0 0 0   0 0 0   1  5f 1 1 0 01 1 04 6 b1 b2 0 0 12c
1 134 00618021 1 0 bb     7 0 ee  3 0 aa  1  5f 1 1 0 06 1 0f 6 0 33 0 0 130
1 138 10640010 0 0 0      7 1 99  0 0 0   1  43 0 0 0 01 1 10 6 0 0 0 0 134
1 138 10640010 0 0 0      7 3 98  0 0 0   1  43 0 0 0 01 1 10 6 0 0 0 0 134
1 138 10640010 0 0 0      5 1 77  0 0 0   1  5f 1 1 0 01 1 10 6 33 77 0 0 134
1 13c 1022fffc 0 0 0      0 0 0   0 0 0   1  7f 1 1 1 15 0 00 7 33 33 40 17c 138
1 140 1422fffc 0 0 0      0 0 0   0 0 0   1  7f 1 1 0 15 0 00 7 b1 b2 fffffff0 130 13c
1 144 14640008 0 0 0      0 0 0   0 0 0   1  7f 1 1 1 16 0 00 7 b1 b2 fffffff0 134 140
1 1ffffffc 0c123456 0 0 0 0 0 0   0 0 0   1  7f 1 1 0 16 0 00 7 33 33 20 168 144
1 200 00a00008 0 0 0      0 0 0   0 0 0   1  7f 1 1 1 17 1 1f 1 0 0 123456 2048d158 1ffffffc
1 204 38511234 0 0 0      0 0 0   0 0 0   1  7f 1 1 1 18 0 00 1 0 0 400020 400020 200
0 0 0         0 0 0       0 0 0   0 0 0   0  5f 0 1 0 0e 1 11 6 b2 1234 0 0 204
0 0 0         0 0 0       0 0 0   0 0 0   0  5f 0 1 0 0e 1 11 6 b2 1234 0 0 204

/* id_stage.f */
design/id_pkg.sv
design/decode_latch.sv
design/inst_decoder.sv
design/reg_file.sv
design/operand_bypass.sv
design/branch_unit.sv
design/id_stage.sv
tests/id_stage_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --assert --top-module id_stage_tb -f id_stage.f -o id_stage_sim; then
  echo "verilator build failed"
  exit 1
fi

if ! out=$(./obj_dir/id_stage_sim); then
  printf '%s\n' "$out"
  echo "simulation exited with an error status"
  exit 1
fi
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "TEST PASS"; then
  exit 0
fi
exit 1

/* tests/id_stage_tb.sv */
`timescale 1ns/1ps

module id_stage_tb
  import id_pkg::*;
();

  localparam int PERIOD  = 20;
  localparam int MAX_VEC = 64;
  localparam int NFIELD  = 26;
  localparam int IDLE_N  = 24;

  logic                  clock;
  logic                  reset;
  logic                  fs_valid_i;
  logic [XLEN-1:0]       fs_pc_i;
  logic [XLEN-1:0]       fs_inst_i;
  logic                  ds_ready_o;
  logic                  wb_we_i;
  logic [REG_ADDR_W-1:0] wb_addr_i;
  logic [XLEN-1:0]       wb_data_i;
  logic                  es_valid_i;
  logic                  es_load_i;
  logic                  es_we_i;
  logic [REG_ADDR_W-1:0] es_addr_i;
  logic [XLEN-1:0]       es_data_i;
  logic                  ms_valid_i;
  logic                  ms_we_i;
  logic [REG_ADDR_W-1:0] ms_addr_i;
  logic [XLEN-1:0]       ms_data_i;
  logic                  es_ready_i;
  logic                  issue_valid_o;
  logic [XLEN-1:0]       issue_pc_o;
  issue_op_e             issue_op_o;
  logic [REG_ADDR_W-1:0] issue_dest_o;
  logic                  issue_dest_en_o;
  logic                  issue_v1_en_o;
  logic [XLEN-1:0]       issue_v1_o;
  logic                  issue_v2_en_o;
  logic [XLEN-1:0]       issue_v2_o;
  logic                  issue_v3_en_o;
  logic [XLEN-1:0]       issue_v3_o;
  logic                  br_taken_o;
  logic [XLEN-1:0]       br_target_o;

  logic [31:0]           vecs [MAX_VEC][NFIELD];
  int                    nvec;
  logic                  loaded;
  int                    errors;
  int                    checks;
  logic [31:0]           rng;
  // outputs at the previous check, for the hold test
  logic                  prev_hold;
  logic [31:0]           prev_pc;
  logic [31:0]           prev_op;
  logic [31:0]           prev_dest;
  logic [31:0]           prev_v1;
  logic [31:0]           prev_v2;
  logic [31:0]           prev_v3;

  id_stage i_dut (.*);

  initial begin
    clock = 1'b0;
    forever #(PERIOD / 2) clock = ~clock;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    checks++;
    assert (act === exp)
      else begin
        errors++;
        $display("FAIL t=%0t %s expected %h actual %h", $time, name, exp, act);
      end
  endtask

  task automatic load_vectors();
    int          fd;
    int          n;
    string       line;
    logic [31:0] f [NFIELD];
    nvec = 0;
    fd = $fopen("tests/id_stage_vectors.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("could not open the vector file tests/id_stage_vectors.txt");
      return;
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() < 2 || line.getc(0) == "#") continue;
      n = $sscanf(line,
        "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
        f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10], f[11], f[12],
        f[13], f[14], f[15], f[16], f[17], f[18], f[19], f[20], f[21], f[22], f[23],
        f[24], f[25]);
      if (n != NFIELD) begin
        errors++;
        $display("vector line has %0d fields instead of %0d: %s", n, NFIELD, line);
      end else if (nvec < MAX_VEC) begin
        vecs[nvec] = f;
        nvec++;
      end else begin
        errors++;
        $display("vector file holds more than %0d lines", MAX_VEC);
      end
    end
    $fclose(fd);
  endtask

  task automatic apply_vector(input int k);
    fs_valid_i = vecs[k][0][0];
    fs_pc_i    = vecs[k][1];
    fs_inst_i  = vecs[k][2];
    wb_we_i    = vecs[k][3][0];
    wb_addr_i  = vecs[k][4][4:0];
    wb_data_i  = vecs[k][5];
    es_valid_i = vecs[k][6][2];
    es_load_i  = vecs[k][6][1];
    es_we_i    = vecs[k][6][0];
    es_addr_i  = vecs[k][7][4:0];
    es_data_i  = vecs[k][8];
    ms_valid_i = vecs[k][9][1];
    ms_we_i    = vecs[k][9][0];
    ms_addr_i  = vecs[k][10][4:0];
    ms_data_i  = vecs[k][11];
    es_ready_i = vecs[k][12][0];
  endtask

  // mask bits: op, dest, v1, v2, v3, target, pc
  task automatic check_vector(input int k);
    logic [31:0] m;
    logic [31:0] en;
    m  = vecs[k][13];
    en = vecs[k][20];
    check_value("ds_ready_o", vecs[k][14], 32'(ds_ready_o));
    check_value("issue_valid_o", vecs[k][15], 32'(issue_valid_o));
    check_value("br_taken_o", vecs[k][16], 32'(br_taken_o));
    if (m[0]) check_value("issue_op_o", vecs[k][17], 32'(issue_op_o));
    if (m[1]) begin
      check_value("issue_dest_en_o", vecs[k][18], 32'(issue_dest_en_o));
      if (vecs[k][18][0]) check_value("issue_dest_o", vecs[k][19], 32'(issue_dest_o));
    end
    if (m[2]) begin
      check_value("issue_v1_en_o", 32'(en[2]), 32'(issue_v1_en_o));
      if (en[2]) check_value("issue_v1_o", vecs[k][21], issue_v1_o);
    end
    if (m[3]) begin
      check_value("issue_v2_en_o", 32'(en[1]), 32'(issue_v2_en_o));
      if (en[1]) check_value("issue_v2_o", vecs[k][22], issue_v2_o);
    end
    if (m[4]) begin
      check_value("issue_v3_en_o", 32'(en[0]), 32'(issue_v3_en_o));
      if (en[0]) check_value("issue_v3_o", vecs[k][23], issue_v3_o);
    end
    if (m[5]) check_value("br_target_o", vecs[k][24], br_target_o);
    if (m[6]) check_value("issue_pc_o", vecs[k][25], issue_pc_o);
  endtask

  task automatic take_snapshot();
    prev_hold = issue_valid_o && !es_ready_i;
    prev_pc   = issue_pc_o;
    prev_op   = 32'(issue_op_o);
    prev_dest = 32'(issue_dest_o);
    prev_v1   = issue_v1_o;
    prev_v2   = issue_v2_o;
    prev_v3   = issue_v3_o;
  endtask

  task automatic check_hold();
    if (prev_hold) begin
      check_value("issue_valid_o", 32'd1, 32'(issue_valid_o));
      check_value("issue_pc_o", prev_pc, issue_pc_o);
      check_value("issue_op_o", prev_op, 32'(issue_op_o));
      check_value("issue_dest_o", prev_dest, 32'(issue_dest_o));
      check_value("issue_v1_o", prev_v1, issue_v1_o);
      check_value("issue_v2_o", prev_v2, issue_v2_o);
      check_value("issue_v3_o", prev_v3, issue_v3_o);
    end
  endtask

  initial begin : watchdog
    wait (loaded);
    #((nvec + 200) * PERIOD);
    $display("watchdog expired before the test sequence finished");
    $display("TEST FAIL");
    $finish;
  end

  initial begin
    reset      = 1'b1;
    fs_valid_i = 1'b0;
    fs_pc_i    = '0;
    fs_inst_i  = '0;
    wb_we_i    = 1'b0;
    wb_addr_i  = '0;
    wb_data_i  = '0;
    es_valid_i = 1'b0;
    es_load_i  = 1'b0;
    es_we_i    = 1'b0;
    es_addr_i  = '0;
    es_data_i  = '0;
    ms_valid_i = 1'b0;
    ms_we_i    = 1'b0;
    ms_addr_i  = '0;
    ms_data_i  = '0;
    es_ready_i = 1'b0;
    errors     = 0;
    checks     = 0;
    loaded     = 1'b0;
    prev_hold  = 1'b0;
    rng        = 32'd67162;
    load_vectors();
    loaded = 1'b1;
    repeat (2) @(posedge clock);
    #2;
    reset = 1'b0;
    for (int k = 0; k < nvec; k++) begin
      apply_vector(k);
      #8;
      check_vector(k);
      take_snapshot();
      @(posedge clock);
      #2;
    end
    // random back-pressure while fetch keeps offering nops at random pcs
    for (int k = 0; k < IDLE_N; k++) begin
      rng        = xorshift(rng);
      fs_valid_i = 1'b1;
      fs_pc_i    = {rng[31:2], 2'b00};
      fs_inst_i  = '0;
      es_ready_i = rng[0];
      #8;
      check_hold();
      take_snapshot();
      @(posedge clock);
      #2;
    end
    $display("vectors: %0d, checks: %0d, errors: %0d", nvec, checks, errors);
    if (errors == 0 && nvec > 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

/* design/id_stage.sv */
`timescale 1ns/1ps

module id_stage
  import id_pkg::*;
(
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  fs_valid_i,
  input  logic [XLEN-1:0]       fs_pc_i,
  input  logic [XLEN-1:0]       fs_inst_i,
  output logic                  ds_ready_o,
  input  logic                  wb_we_i,
  input  logic [REG_ADDR_W-1:0] wb_addr_i,
  input  logic [XLEN-1:0]       wb_data_i,
  input  logic                  es_valid_i,
  input  logic                  es_load_i,
  input  logic                  es_we_i,
  input  logic [REG_ADDR_W-1:0] es_addr_i,
  input  logic [XLEN-1:0]       es_data_i,
  input  logic                  ms_valid_i,
  input  logic                  ms_we_i,
  input  logic [REG_ADDR_W-1:0] ms_addr_i,
  input  logic [XLEN-1:0]       ms_data_i,
  input  logic                  es_ready_i,
  output logic                  issue_valid_o,
  output logic [XLEN-1:0]       issue_pc_o,
  output issue_op_e             issue_op_o,
  output logic [REG_ADDR_W-1:0] issue_dest_o,
  output logic                  issue_dest_en_o,
  output logic                  issue_v1_en_o,
  output logic [XLEN-1:0]       issue_v1_o,
  output logic                  issue_v2_en_o,
  output logic [XLEN-1:0]       issue_v2_o,
  output logic                  issue_v3_en_o,
  output logic [XLEN-1:0]       issue_v3_o,
  output logic                  br_taken_o,
  output logic [XLEN-1:0]       br_target_o
);

  logic                  ds_valid;
  logic [XLEN-1:0]       ds_inst;
  logic                  load_hazard;
  v1_src_e               v1_src;
  v2_src_e               v2_src;
  v3_src_e               v3_src;
  logic [REG_ADDR_W-1:0] rs;
  logic [REG_ADDR_W-1:0] rt;
  logic [15:0]           imm;
  logic [4:0]            sa;
  logic [25:0]           index;
  logic                  is_beq;
  logic                  is_bne;
  logic                  is_jr;
  logic                  is_jal;
  logic [REG_ADDR_W-1:0] raddr0;
  logic [REG_ADDR_W-1:0] raddr1;
  logic [XLEN-1:0]       rdata0;
  logic [XLEN-1:0]       rdata1;

  decode_latch i_latch (
    .clock         (clock),
    .reset         (reset),
    .fs_valid_i    (fs_valid_i),
    .fs_pc_i       (fs_pc_i),
    .fs_inst_i     (fs_inst_i),
    .stall_i       (load_hazard),
    .es_ready_i    (es_ready_i),
    .ds_ready_o    (ds_ready_o),
    .ds_valid_o    (ds_valid),
    .issue_valid_o (issue_valid_o),
    .ds_pc_o       (issue_pc_o),
    .ds_inst_o     (ds_inst)
  );

  inst_decoder i_decoder (
    .inst_i    (ds_inst),
    .op_o      (issue_op_o),
    .v1_src_o  (v1_src),
    .v2_src_o  (v2_src),
    .v3_src_o  (v3_src),
    .dest_o    (issue_dest_o),
    .dest_en_o (issue_dest_en_o),
    .rs_o      (rs),
    .rt_o      (rt),
    .imm_o     (imm),
    .sa_o      (sa),
    .index_o   (index),
    .is_beq_o  (is_beq),
    .is_bne_o  (is_bne),
    .is_jr_o   (is_jr),
    .is_jal_o  (is_jal)
  );

  reg_file i_regs (
    .clock    (clock),
    .raddr0_i (raddr0),
    .raddr1_i (raddr1),
    .we_i     (wb_we_i),
    .waddr_i  (wb_addr_i),
    .wdata_i  (wb_data_i),
    .rdata0_o (rdata0),
    .rdata1_o (rdata1)
  );

  operand_bypass i_bypass (
    .v1_src_i      (v1_src),
    .v2_src_i      (v2_src),
    .v3_src_i      (v3_src),
    .rs_i          (rs),
    .rt_i          (rt),
    .imm_i         (imm),
    .sa_i          (sa),
    .index_i       (index),
    .rdata0_i      (rdata0),
    .rdata1_i      (rdata1),
    .wb_we_i       (wb_we_i),
    .wb_addr_i     (wb_addr_i),
    .wb_data_i     (wb_data_i),
    .es_valid_i    (es_valid_i),
    .es_load_i     (es_load_i),
    .es_we_i       (es_we_i),
    .es_addr_i     (es_addr_i),
    .es_data_i     (es_data_i),
    .ms_valid_i    (ms_valid_i),
    .ms_we_i       (ms_we_i),
    .ms_addr_i     (ms_addr_i),
    .ms_data_i     (ms_data_i),
    .raddr0_o      (raddr0),
    .raddr1_o      (raddr1),
    .v1_en_o       (issue_v1_en_o),
    .v1_o          (issue_v1_o),
    .v2_en_o       (issue_v2_en_o),
    .v2_o          (issue_v2_o),
    .v3_en_o       (issue_v3_en_o),
    .v3_o          (issue_v3_o),
    .load_hazard_o (load_hazard)
  );

  branch_unit i_branch (
    .ds_valid_i  (ds_valid),
    .pc_i        (issue_pc_o),
    .is_beq_i    (is_beq),
    .is_bne_i    (is_bne),
    .is_jr_i     (is_jr),
    .is_jal_i    (is_jal),
    .v1_i        (issue_v1_o),
    .v2_i        (issue_v2_o),
    .v3_i        (issue_v3_o),
    .br_taken_o  (br_taken_o),
    .br_target_o (br_target_o)
  );

endmodule

/* design/branch_unit.sv */
`timescale 1ns/1ps

module branch_unit
  import id_pkg::*;
(
  input  logic            ds_valid_i,
  input  logic [XLEN-1:0] pc_i,
  input  logic            is_beq_i,
  input  logic            is_bne_i,
  input  logic            is_jr_i,
  input  logic            is_jal_i,
  input  logic [XLEN-1:0] v1_i,
  input  logic [XLEN-1:0] v2_i,
  input  logic [XLEN-1:0] v3_i,
  output logic            br_taken_o,
  output logic [XLEN-1:0] br_target_o
);

  logic [XLEN-1:0] pc_plus4;
  logic            equal;

  assign pc_plus4 = pc_i + 32'd4;
  assign equal    = (v1_i == v2_i);

  assign br_taken_o = ds_valid_i &&
                      ((is_beq_i && equal) || (is_bne_i && !equal) || is_jr_i || is_jal_i);

  always_comb begin
    if (is_beq_i || is_bne_i) begin
      br_target_o = pc_plus4 + v3_i;
    end else if (is_jr_i) begin
      br_target_o = v3_i;
    end else begin
      // jal stays in the current 256MB region
      br_target_o = {pc_plus4[XLEN-1:XLEN-4], v3_i[25:0], 2'b00};
    end
  end

endmodule

/* design/operand_bypass.sv */
`timescale 1ns/1ps

module operand_bypass
  import id_pkg::*;
(
  input  v1_src_e               v1_src_i,
  input  v2_src_e               v2_src_i,
  input  v3_src_e               v3_src_i,
  input  logic [REG_ADDR_W-1:0] rs_i,
  input  logic [REG_ADDR_W-1:0] rt_i,
  input  logic [15:0]           imm_i,
  input  logic [4:0]            sa_i,
  input  logic [25:0]           index_i,
  input  logic [XLEN-1:0]       rdata0_i,
  input  logic [XLEN-1:0]       rdata1_i,
  input  logic                  wb_we_i,
  input  logic [REG_ADDR_W-1:0] wb_addr_i,
  input  logic [XLEN-1:0]       wb_data_i,
  input  logic                  es_valid_i,
  input  logic                  es_load_i,
  input  logic                  es_we_i,
  input  logic [REG_ADDR_W-1:0] es_addr_i,
  input  logic [XLEN-1:0]       es_data_i,
  input  logic                  ms_valid_i,
  input  logic                  ms_we_i,
  input  logic [REG_ADDR_W-1:0] ms_addr_i,
  input  logic [XLEN-1:0]       ms_data_i,
  output logic [REG_ADDR_W-1:0] raddr0_o,
  output logic [REG_ADDR_W-1:0] raddr1_o,
  output logic                  v1_en_o,
  output logic [XLEN-1:0]       v1_o,
  output logic                  v2_en_o,
  output logic [XLEN-1:0]       v2_o,
  output logic                  v3_en_o,
  output logic [XLEN-1:0]       v3_o,
  output logic                  load_hazard_o
);

  logic            use0;
  logic            use1;
  logic [XLEN-1:0] fwd0;
  logic [XLEN-1:0] fwd1;

  // newest producer wins, register 0 never forwards
  function automatic logic [XLEN-1:0] pick(input logic [REG_ADDR_W-1:0] addr,
                                           input logic [XLEN-1:0]       rdata);
    logic nz;
    nz = (addr != '0);
    if (nz && es_valid_i && es_we_i && (es_addr_i == addr)) begin
      pick = es_data_i;
    end else if (nz && ms_valid_i && ms_we_i && (ms_addr_i == addr)) begin
      pick = ms_data_i;
    end else if (nz && wb_we_i && (wb_addr_i == addr)) begin
      pick = wb_data_i;
    end else begin
      pick = rdata;
    end
  endfunction

  assign raddr0_o = (v1_src_i == V1_RT) ? rt_i : rs_i;
  assign raddr1_o = (v3_src_i == V3_RS) ? rs_i : rt_i;

  assign use0 = (v1_src_i == V1_RS) || (v1_src_i == V1_RT);
  assign use1 = (v2_src_i == V2_RT) || (v3_src_i == V3_RS) || (v3_src_i == V3_RT);

  always_comb begin
    fwd0 = pick(raddr0_o, rdata0_i);
    fwd1 = pick(raddr1_o, rdata1_i);
  end

  // load result is not ready until the memory stage
  assign load_hazard_o = es_valid_i && es_load_i && es_we_i && (es_addr_i != '0) &&
                         ((use0 && (es_addr_i == raddr0_o)) ||
                          (use1 && (es_addr_i == raddr1_o)));

  assign v1_en_o = (v1_src_i != V1_NONE);
  assign v2_en_o = (v2_src_i != V2_NONE);
  assign v3_en_o = (v3_src_i != V3_NONE);

  always_comb begin
    case (v1_src_i)
      V1_RS, V1_RT: v1_o = fwd0;
      V1_UPPER:     v1_o = {imm_i, 16'h0};
      default:      v1_o = '0;
    endcase

    case (v2_src_i)
      V2_RT:   v2_o = fwd1;
      V2_SIGN: v2_o = {{(XLEN-16){imm_i[15]}}, imm_i};
      V2_ZERO: v2_o = {{(XLEN-16){1'b0}}, imm_i};
      V2_SA:   v2_o = {{(XLEN-5){1'b0}}, sa_i};
      default: v2_o = '0;
    endcase

    case (v3_src_i)
      V3_RS, V3_RT: v3_o = fwd1;
      // word offset to byte offset
      V3_OFFSET:    v3_o = {{(XLEN-18){imm_i[15]}}, imm_i, 2'b00};
      V3_INDEX:     v3_o = {{(XLEN-26){1'b0}}, index_i};
      default:      v3_o = '0;
    endcase
  end

endmodule

/* design/reg_file.sv */
`timescale 1ns/1ps

module reg_file
  import id_pkg::*;
(
  input  logic                  clock,
  input  logic [REG_ADDR_W-1:0] raddr0_i,
  input  logic [REG_ADDR_W-1:0] raddr1_i,
  input  logic                  we_i,
  input  logic [REG_ADDR_W-1:0] waddr_i,
  input  logic [XLEN-1:0]       wdata_i,
  output logic [XLEN-1:0]       rdata0_o,
  output logic [XLEN-1:0]       rdata1_o
);

  logic [XLEN-1:0] regs [0:(1<<REG_ADDR_W)-1];

  // entry 0 is never written and never read
  always_ff @(posedge clock) begin
    if (we_i && (waddr_i != '0)) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  assign rdata0_o = (raddr0_i == '0) ? '0 : regs[raddr0_i];
  assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];

endmodule

/* design/inst_decoder.sv */
`timescale 1ns/1ps

module inst_decoder
  import id_pkg::*;
(
  input  logic [XLEN-1:0]       inst_i,
  output issue_op_e             op_o,
  output v1_src_e               v1_src_o,
  output v2_src_e               v2_src_o,
  output v3_src_e               v3_src_o,
  output logic [REG_ADDR_W-1:0] dest_o,
  output logic                  dest_en_o,
  output logic [REG_ADDR_W-1:0] rs_o,
  output logic [REG_ADDR_W-1:0] rt_o,
  output logic [15:0]           imm_o,
  output logic [4:0]            sa_o,
  output logic [25:0]           index_o,
  output logic                  is_beq_o,
  output logic                  is_bne_o,
  output logic                  is_jr_o,
  output logic                  is_jal_o
);

  logic [5:0]            opcode;
  logic [5:0]            funct;
  logic [REG_ADDR_W-1:0] rd;
  logic                  rs_zero;
  logic                  rt_zero;
  logic                  rd_zero;
  logic                  sa_zero;

  assign opcode  = inst_i[31:26];
  assign rs_o    = inst_i[25:21];
  assign rt_o    = inst_i[20:16];
  assign rd      = inst_i[15:11];
  assign sa_o    = inst_i[10:6];
  assign funct   = inst_i[5:0];
  assign imm_o   = inst_i[15:0];
  assign index_o = inst_i[25:0];

  assign rs_zero = (rs_o == '0);
  assign rt_zero = (rt_o == '0);
  assign rd_zero = (rd == '0);
  assign sa_zero = (sa_o == '0);

  always_comb begin
    op_o      = OP_NONE;
    v1_src_o  = V1_NONE;
    v2_src_o  = V2_NONE;
    v3_src_o  = V3_NONE;
    dest_o    = '0;
    dest_en_o = 1'b0;

    // reserved fields must be zero, as in the full ISA
    case (opcode)
      OPC_SPECIAL: begin
        if (sa_zero) begin
          case (funct)
            FN_ADDU: op_o = OP_ADDU;
            FN_SUBU: op_o = OP_SUBU;
            FN_SLT:  op_o = OP_SLT;
            FN_SLTU: op_o = OP_SLTU;
            FN_AND:  op_o = OP_AND;
            FN_OR:   op_o = OP_OR;
            FN_XOR:  op_o = OP_XOR;
            FN_NOR:  op_o = OP_NOR;
            FN_JR:   if (rt_zero && rd_zero) op_o = OP_JR;
            default: ;
          endcase
        end
        if (rs_zero) begin
          case (funct)
            FN_SLL:  op_o = OP_SLL;
            FN_SRL:  op_o = OP_SRL;
            FN_SRA:  op_o = OP_SRA;
            default: ;
          endcase
        end
      end
      OPC_ADDIU: op_o = OP_ADDIU;
      OPC_SLTI:  op_o = OP_SLTI;
      OPC_SLTIU: op_o = OP_SLTIU;
      OPC_ANDI:  op_o = OP_ANDI;
      OPC_ORI:   op_o = OP_ORI;
      OPC_XORI:  op_o = OP_XORI;
      OPC_LUI:   if (rs_zero) op_o = OP_LUI;
      OPC_LW:    op_o = OP_LW;
      OPC_SW:    op_o = OP_SW;
      OPC_BEQ:   op_o = OP_BEQ;
      OPC_BNE:   op_o = OP_BNE;
      OPC_JAL:   op_o = OP_JAL;
      default:   ;
    endcase

    case (op_o)
      OP_ADDU, OP_SUBU, OP_SLT, OP_SLTU, OP_AND, OP_OR, OP_XOR, OP_NOR: begin
        v1_src_o  = V1_RS;
        v2_src_o  = V2_RT;
        dest_o    = rd;
        dest_en_o = 1'b1;
      end
      OP_SLL, OP_SRL, OP_SRA: begin
        v1_src_o  = V1_RT;
        v2_src_o  = V2_SA;
        dest_o    = rd;
        dest_en_o = 1'b1;
      end
      OP_ADDIU, OP_SLTI, OP_SLTIU, OP_LW: begin
        v1_src_o  = V1_RS;
        v2_src_o  = V2_SIGN;
        dest_o    = rt_o;
        dest_en_o = 1'b1;
      end
      OP_ANDI, OP_ORI, OP_XORI: begin
        v1_src_o  = V1_RS;
        v2_src_o  = V2_ZERO;
        dest_o    = rt_o;
        dest_en_o = 1'b1;
      end
      OP_LUI: begin
        v1_src_o  = V1_UPPER;
        dest_o    = rt_o;
        dest_en_o = 1'b1;
      end
      OP_SW: begin
        v1_src_o = V1_RS;
        v2_src_o = V2_SIGN;
        v3_src_o = V3_RT;
      end
      OP_BEQ, OP_BNE: begin
        v1_src_o = V1_RS;
        v2_src_o = V2_RT;
        v3_src_o = V3_OFFSET;
      end
      OP_JAL: begin
        v3_src_o  = V3_INDEX;
        // link register
        dest_o    = 5'd31;
        dest_en_o = 1'b1;
      end
      OP_JR:   v3_src_o = V3_RS;
      default: ;
    endcase
  end

  assign is_beq_o = (op_o == OP_BEQ);
  assign is_bne_o = (op_o == OP_BNE);
  assign is_jr_o  = (op_o == OP_JR);
  assign is_jal_o = (op_o == OP_JAL);

endmodule

/* design/decode_latch.sv */
`timescale 1ns/1ps

module decode_latch
  import id_pkg::*;
(
  input  logic            clock,
  input  logic            reset,
  input  logic            fs_valid_i,
  input  logic [XLEN-1:0] fs_pc_i,
  input  logic [XLEN-1:0] fs_inst_i,
  input  logic            stall_i,
  input  logic            es_ready_i,
  output logic            ds_ready_o,
  output logic            ds_valid_o,
  output logic            issue_valid_o,
  output logic [XLEN-1:0] ds_pc_o,
  output logic [XLEN-1:0] ds_inst_o
);

  // empty, or the held instruction leaves this cycle
  assign ds_ready_o    = !ds_valid_o || (!stall_i && es_ready_i);
  assign issue_valid_o = ds_valid_o && !stall_i;

  always_ff @(posedge clock) begin
    if (reset) begin
      ds_valid_o <= 1'b0;
    end else if (ds_ready_o) begin
      ds_valid_o <= fs_valid_i;
    end
  end

  always_ff @(posedge clock) begin
    if (fs_valid_i && ds_ready_o) begin
      ds_pc_o   <= fs_pc_i;
      ds_inst_o <= fs_inst_i;
    end
  end

endmodule

/* design/id_pkg.sv */
package id_pkg;

  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;

  // internal operation codes, OP_NONE for anything not decoded
  typedef enum logic [7:0] {
    OP_NONE  = 8'h00,
    OP_ADDU  = 8'h01,
    OP_SUBU  = 8'h02,
    OP_SLT   = 8'h03,
    OP_SLTU  = 8'h04,
    OP_AND   = 8'h05,
    OP_OR    = 8'h06,
    OP_XOR   = 8'h07,
    OP_NOR   = 8'h08,
    OP_ADDIU = 8'h09,
    OP_SLTI  = 8'h0a,
    OP_SLTIU = 8'h0b,
    OP_ANDI  = 8'h0c,
    OP_ORI   = 8'h0d,
    OP_XORI  = 8'h0e,
    OP_LUI   = 8'h0f,
    OP_SLL   = 8'h10,
    OP_SRL   = 8'h11,
    OP_SRA   = 8'h12,
    OP_LW    = 8'h13,
    OP_SW    = 8'h14,
    OP_BEQ   = 8'h15,
    OP_BNE   = 8'h16,
    OP_JAL   = 8'h17,
    OP_JR    = 8'h18
  } issue_op_e;

  typedef enum logic [1:0] {V1_NONE, V1_RS, V1_RT, V1_UPPER} v1_src_e;
  typedef enum logic [2:0] {V2_NONE, V2_RT, V2_SIGN, V2_ZERO, V2_SA} v2_src_e;
  typedef enum logic [2:0] {V3_NONE, V3_RS, V3_RT, V3_OFFSET, V3_INDEX} v3_src_e;

  // primary opcode field
  localparam logic [5:0] OPC_SPECIAL = 6'h00;
  localparam logic [5:0] OPC_JAL     = 6'h03;
  localparam logic [5:0] OPC_BEQ     = 6'h04;
  localparam logic [5:0] OPC_BNE     = 6'h05;
  localparam logic [5:0] OPC_ADDIU   = 6'h09;
  localparam logic [5:0] OPC_SLTI    = 6'h0a;
  localparam logic [5:0] OPC_SLTIU   = 6'h0b;
  localparam logic [5:0] OPC_ANDI    = 6'h0c;
  localparam logic [5:0] OPC_ORI     = 6'h0d;
  localparam logic [5:0] OPC_XORI    = 6'h0e;
  localparam logic [5:0] OPC_LUI     = 6'h0f;
  localparam logic [5:0] OPC_LW      = 6'h23;
  localparam logic [5:0] OPC_SW      = 6'h2b;

  // function field of SPECIAL
  localparam logic [5:0] FN_SLL  = 6'h00;
  localparam logic [5:0] FN_SRL  = 6'h02;
  localparam logic [5:0] FN_SRA  = 6'h03;
  localparam logic [5:0] FN_JR   = 6'h08;
  localparam logic [5:0] FN_ADDU = 6'h21;
  localparam logic [5:0] FN_SUBU = 6'h23;
  localparam logic [5:0] FN_AND  = 6'h24;
  localparam logic [5:0] FN_OR   = 6'h25;
  localparam logic [5:0] FN_XOR  = 6'h26;
  localparam logic [5:0] FN_NOR  = 6'h27;
  localparam logic [5:0] FN_SLT  = 6'h2a;
  localparam logic [5:0] FN_SLTU = 6'h2b;

endpackage
